/* logic/agg_params.svh */
// sizes assume a 64-bit stream whose custom header word is the fifth beat; change all together
`ifndef AGG_PARAMS_SVH
`define AGG_PARAMS_SVH

// stream geometry
`define AGG_DATA_W 64
`define AGG_USER_W 128
`define AGG_LANE_W 32    // one aggregated value, two per beat

// packet layout
`define AGG_HDR_BEATS 5  // ethernet + ip + custom word
`define AGG_FIN_BIT 52   // inside header beat 4, packet bit 308

// ingress buffering, 32 beats per port
`define AGG_FIFO_DEPTH_BITS 5

// destination written into bits 47:0 of header beat 0
`define AGG_NEW_DEST_MAC 48'hffff_ffff_ffff

`endif

/* logic/axis_pkg.sv */
// one AXI-Stream beat as stored and moved inside the engine; tkeep is one bit per data byte
`include "agg_params.svh"

package axis_pkg;

  // tdata sits in the top bits, tlast in bit 0
  typedef struct packed {
    logic [`AGG_DATA_W-1:0]   tdata;
    logic [`AGG_DATA_W/8-1:0] tkeep;
    logic [`AGG_USER_W-1:0]   tuser;
    logic                     tlast;
  } beat_t;

endpackage

/* logic/agg_pkg.sv */
// custom header word layout and lane view of a data word; lanes are unsigned 32-bit integers
`include "agg_params.svh"

package agg_pkg;

  localparam int lane_count = `AGG_DATA_W / `AGG_LANE_W;
  localparam int vidx_lsb = 20;                            // below: reserved, opcode, padding
  localparam int vidx_w = `AGG_FIN_BIT - vidx_lsb;
  localparam int nvar_w = `AGG_DATA_W - `AGG_FIN_BIT - 1;

  // custom header word, msb first
  typedef struct packed {
    logic [nvar_w-1:0] num_vars;
    logic              fin;       // last vector of a run, index restarts
    logic [vidx_w-1:0] vector_index;
    logic [1:0]        padding;
    logic [1:0]        opcode;
    logic [15:0]       rsvd;      // tail of the ip header
  } agg_hdr_t;

  // header beat 4 and payload beats share one word
  typedef union packed {
    agg_hdr_t                                hdr;
    logic [lane_count-1:0][`AGG_LANE_W-1:0] lanes;  // lane 0 in bits 31:0
  } agg_word_u;

endpackage

/* logic/beat_fifo.sv */
// fall-through beat FIFO; a write is visible one cycle later, writers must stop at nearly_full
`include "agg_params.svh"

module beat_fifo #(
  parameter int depth_bits = `AGG_FIFO_DEPTH_BITS
) (
  input  logic            axis_aclk,
  input  logic            axis_resetn,
  input  axis_pkg::beat_t wr_beat,
  input  logic            wr_en,
  input  logic            rd_en,
  output axis_pkg::beat_t rd_beat,
  output logic            empty,
  output logic            nearly_full
);

  localparam int depth = 2 ** depth_bits;

  axis_pkg::beat_t       mem [depth];
  logic [depth_bits-1:0] wr_ptr;
  logic [depth_bits-1:0] rd_ptr;
  logic [depth_bits:0]   count;
  logic [depth_bits:0]   count_next;
  logic                  full;

  assign empty = (count == '0);
  assign full = (count == (depth_bits + 1)'(depth));
  assign rd_beat = mem[rd_ptr];  // head shows without a read

  always_comb begin
    case ({wr_en, rd_en})
      2'b10:   count_next = count + 1'b1;
      2'b01:   count_next = count - 1'b1;
      default: count_next = count;
    endcase
  end

  always_ff @(posedge axis_aclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_beat;
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      nearly_full <= 1'b1;  // keeps tready low until out of reset
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count_next;
      // two entries of slack for beats already on the way
      nearly_full <= (count_next >= (depth_bits + 1)'(depth - 2));
    end
  end

  assert property (@(posedge axis_aclk) disable iff (!axis_resetn) wr_en |-> !full)
    else $error("beat_fifo: write while full");

  assert property (@(posedge axis_aclk) disable iff (!axis_resetn) rd_en |-> !empty)
    else $error("beat_fifo: read while empty");

endmodule

/* logic/port_ingress.sv */
// one input port; packets need at least one payload beat after the header
`include "agg_params.svh"

module port_ingress #(
  parameter int depth_bits = `AGG_FIFO_DEPTH_BITS
) (
  input  logic                                  axis_aclk,
  input  logic                                  axis_resetn,
  input  axis_pkg::beat_t                       s_beat,
  input  logic                                  s_tvalid,
  output logic                                  s_tready,
  output axis_pkg::beat_t [`AGG_HDR_BEATS-1:0] hdr,
  output logic                                  hdr_valid,
  output axis_pkg::beat_t                       pay_beat,
  output logic                                  pay_avail,
  input  logic                                  pay_pop,
  input  logic                                  hdr_done
);

  typedef enum logic [1:0] {
    st_capture,
    st_held,
    st_payload
  } state_t;

  localparam int cnt_w = $clog2(`AGG_HDR_BEATS);

  state_t           state;
  logic [cnt_w-1:0] hdr_cnt;
  logic             fifo_empty;
  logic             fifo_nearly_full;
  logic             fifo_rd_en;
  logic             take_hdr;

  beat_fifo #(
    .depth_bits(depth_bits)
  ) u_fifo (
    .axis_aclk  (axis_aclk),
    .axis_resetn(axis_resetn),
    .wr_beat    (s_beat),
    .wr_en      (s_tvalid && s_tready),
    .rd_en      (fifo_rd_en),
    .rd_beat    (pay_beat),  // head beat, header or payload
    .empty      (fifo_empty),
    .nearly_full(fifo_nearly_full)
  );

  assign s_tready = !fifo_nearly_full;

  assign take_hdr = (state == st_capture) && !fifo_empty;
  assign pay_avail = (state == st_payload) && !fifo_empty;
  assign hdr_valid = (state == st_held);
  assign fifo_rd_en = take_hdr || (pay_avail && pay_pop);

  // oldest header beat ends up in hdr[0]
  always_ff @(posedge axis_aclk) begin
    if (take_hdr) begin
      hdr <= {pay_beat, hdr[`AGG_HDR_BEATS-1:1]};
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      state <= st_capture;
      hdr_cnt <= '0;
    end else begin
      case (state)
        st_capture: begin
          if (take_hdr) begin
            if (hdr_cnt == cnt_w'(`AGG_HDR_BEATS - 1)) begin
              hdr_cnt <= '0;
              state <= st_held;
            end else begin
              hdr_cnt <= hdr_cnt + 1'b1;
            end
          end
        end
        st_held: begin
          if (hdr_done) begin
            state <= st_payload;  // combiner has sent the header
          end
        end
        st_payload: begin
          if (fifo_rd_en && pay_beat.tlast) begin
            state <= st_capture;
          end
        end
        default: state <= st_capture;
      endcase
    end
  end

  // combiner must only pop what this port offers
  assert property (@(posedge axis_aclk) disable iff (!axis_resetn) pay_pop |-> pay_avail)
    else $error("port_ingress: pay_pop without pay_avail");

endmodule

/* logic/agg_combine.sv */
// port 0 is master for header and framing; both ports must send equal payload lengths
`include "agg_params.svh"

module agg_combine (
  input  logic                                  axis_aclk,
  input  logic                                  axis_resetn,
  input  axis_pkg::beat_t [`AGG_HDR_BEATS-1:0] hdr0,
  input  axis_pkg::beat_t [`AGG_HDR_BEATS-1:0] hdr1,
  input  logic                                  hdr0_valid,
  input  logic                                  hdr1_valid,
  input  axis_pkg::beat_t                       pay0_beat,
  input  axis_pkg::beat_t                       pay1_beat,
  input  logic                                  pay0_avail,
  input  logic                                  pay1_avail,
  output logic                                  pay_pop,
  output logic                                  hdr_done,
  output axis_pkg::beat_t                       m_beat,
  output logic                                  m_tvalid,
  input  logic                                  m_tready,
  output logic [agg_pkg::vidx_w-1:0]            vector_index
);

  typedef enum logic [1:0] {
    st_wait,
    st_hdr,
    st_pay
  } state_t;

  localparam int cnt_w = $clog2(`AGG_HDR_BEATS);
  localparam int last_hdr_idx = `AGG_HDR_BEATS - 1;

  state_t             state;
  logic [cnt_w-1:0]   hdr_cnt;
  logic               last_hdr;
  logic               start;
  agg_pkg::agg_word_u ctl_word;    // master custom header word
  agg_pkg::agg_word_u lane0_word;
  agg_pkg::agg_word_u lane1_word;
  agg_pkg::agg_word_u sum_word;

  assign ctl_word = hdr0[last_hdr_idx].tdata;
  assign lane0_word = pay0_beat.tdata;
  assign lane1_word = pay1_beat.tdata;

  assign start = (state == st_wait) && hdr0_valid && hdr1_valid;
  assign last_hdr = (hdr_cnt == cnt_w'(last_hdr_idx));
  assign hdr_done = (state == st_hdr) && m_tready && last_hdr;
  assign pay_pop = (state == st_pay) && m_tvalid && m_tready;  // both ports together

  // wrapping integer add per lane
  always_comb begin
    for (int i = 0; i < agg_pkg::lane_count; i++) begin
      sum_word.lanes[i] = lane0_word.lanes[i] + lane1_word.lanes[i];
    end
  end

  always_comb begin
    m_beat = pay0_beat;  // keep, user and last from the master
    m_tvalid = 1'b0;
    case (state)
      st_hdr: begin
        m_beat = hdr0[hdr_cnt];
        if (hdr_cnt == '0) begin
          m_beat.tdata[47:0] = `AGG_NEW_DEST_MAC;
        end
        m_tvalid = 1'b1;
      end
      st_pay: begin
        m_beat.tdata = sum_word;
        m_tvalid = pay0_avail && pay1_avail;  // slower port sets the pace
      end
      default: begin
        m_tvalid = 1'b0;
      end
    endcase
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      state <= st_wait;
      hdr_cnt <= '0;
      vector_index <= '0;
    end else begin
      case (state)
        st_wait: begin
          if (start) begin
            state <= st_hdr;
          end
        end
        st_hdr: begin
          if (m_tready) begin
            if (last_hdr) begin
              hdr_cnt <= '0;
              state <= st_pay;
              // fin closes a run of vectors
              vector_index <= ctl_word.hdr.fin ? '0 : vector_index + 1'b1;
            end else begin
              hdr_cnt <= hdr_cnt + 1'b1;
            end
          end
        end
        st_pay: begin
          if (pay_pop && pay0_beat.tlast) begin
            state <= st_wait;
          end
        end
        default: state <= st_wait;
      endcase
    end
  end

  // both packets of a pair end on the same payload beat
  assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
    pay_pop |-> (pay0_beat.tlast == pay1_beat.tlast))
    else $error("agg_combine: payload lengths differ between ports");

  // a header alone would leave the payload phase waiting forever
  assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
    start |-> (!hdr0[last_hdr_idx].tlast && !hdr1[last_hdr_idx].tlast))
    else $error("agg_combine: packet without payload");

endmodule

/* logic/agg_top.sv */
// two-port aggregation; port 0 is master and the output has no per-port selection
`include "agg_params.svh"

module agg_top (
  input  logic                   axis_aclk,
  input  logic                   axis_resetn,
  input  axis_pkg::beat_t        s0_beat,
  input  logic                   s0_tvalid,
  output logic                   s0_tready,
  input  axis_pkg::beat_t        s1_beat,
  input  logic                   s1_tvalid,
  output logic                   s1_tready,
  output axis_pkg::beat_t        m_beat,
  output logic                   m_tvalid,
  input  logic                   m_tready,
  output logic [agg_pkg::vidx_w-1:0] vector_index
);

  axis_pkg::beat_t [`AGG_HDR_BEATS-1:0] hdr0;
  axis_pkg::beat_t [`AGG_HDR_BEATS-1:0] hdr1;
  axis_pkg::beat_t                       pay0_beat;
  axis_pkg::beat_t                       pay1_beat;
  logic                                  hdr0_valid;
  logic                                  hdr1_valid;
  logic                                  pay0_avail;
  logic                                  pay1_avail;
  logic                                  pay_pop;
  logic                                  hdr_done;

  port_ingress #(
    .depth_bits(`AGG_FIFO_DEPTH_BITS)
  ) u_ing0 (
    .axis_aclk  (axis_aclk),
    .axis_resetn(axis_resetn),
    .s_beat     (s0_beat),
    .s_tvalid   (s0_tvalid),
    .s_tready   (s0_tready),
    .hdr        (hdr0),
    .hdr_valid  (hdr0_valid),
    .pay_beat   (pay0_beat),
    .pay_avail  (pay0_avail),
    .pay_pop    (pay_pop),
    .hdr_done   (hdr_done)
  );

  port_ingress #(
    .depth_bits(`AGG_FIFO_DEPTH_BITS)
  ) u_ing1 (
    .axis_aclk  (axis_aclk),
    .axis_resetn(axis_resetn),
    .s_beat     (s1_beat),
    .s_tvalid   (s1_tvalid),
    .s_tready   (s1_tready),
    .hdr        (hdr1),
    .hdr_valid  (hdr1_valid),
    .pay_beat   (pay1_beat),
    .pay_avail  (pay1_avail),
    .pay_pop    (pay_pop),
    .hdr_done   (hdr_done)
  );

  agg_combine u_comb (
    .axis_aclk   (axis_aclk),
    .axis_resetn (axis_resetn),
    .hdr0        (hdr0),
    .hdr1        (hdr1),
    .hdr0_valid  (hdr0_valid),
    .hdr1_valid  (hdr1_valid),
    .pay0_beat   (pay0_beat),
    .pay1_beat   (pay1_beat),
    .pay0_avail  (pay0_avail),
    .pay1_avail  (pay1_avail),
    .pay_pop     (pay_pop),
    .hdr_done    (hdr_done),
    .m_beat      (m_beat),
    .m_tvalid    (m_tvalid),
    .m_tready    (m_tready),
    .vector_index(vector_index)
  );

endmodule

/* bench/agg_tb.sv */
// directed tests of agg_top; inputs move 1 ns after the rising edge, output collected on transfer
`include "agg_params.svh"

module agg_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int timeout_cycles = 2000;

  logic                         axis_aclk = 1'b0;
  logic                         axis_resetn;
  axis_pkg::beat_t              s0_beat;
  logic                         s0_tvalid;
  logic                         s0_tready;
  axis_pkg::beat_t              s1_beat;
  logic                         s1_tvalid;
  logic                         s1_tready;
  axis_pkg::beat_t              m_beat;
  logic                         m_tvalid;
  logic                         m_tready;
  logic [agg_pkg::vidx_w-1:0]   vector_index;

  axis_pkg::beat_t pkt0_q[$];  // port 0 packet to send
  axis_pkg::beat_t pkt1_q[$];
  axis_pkg::beat_t exp_q[$];   // expected output packet
  axis_pkg::beat_t out_q[$];   // collected output beats

  logic [31:0] lfsr = 32'hc327_61ef;
  int          checks = 0;
  int          errors = 0;
  logic        busy = 1'b0;
  logic        s0_was_full = 1'b0;

  agg_top DUT (
    .axis_aclk   (axis_aclk),
    .axis_resetn (axis_resetn),
    .s0_beat     (s0_beat),
    .s0_tvalid   (s0_tvalid),
    .s0_tready   (s0_tready),
    .s1_beat     (s1_beat),
    .s1_tvalid   (s1_tvalid),
    .s1_tready   (s1_tready),
    .m_beat      (m_beat),
    .m_tvalid    (m_tvalid),
    .m_tready    (m_tready),
    .vector_index(vector_index)
  );

  always #2 axis_aclk = ~axis_aclk;

  // output monitor
  always @(posedge axis_aclk) begin
    if (axis_resetn && m_tvalid && m_tready) begin
      out_q.push_back(m_beat);
    end
    if (axis_resetn && !s0_tready) begin
      s0_was_full = 1'b1;  // port 0 saw back-pressure
    end
  end

  // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic axis_pkg::beat_t random_beat();
    axis_pkg::beat_t b;
    b.tdata = {rand_bits(32), rand_bits(32)};
    b.tkeep = 8'(rand_bits(8));
    b.tuser = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
    b.tlast = 1'b0;
    return b;
  endfunction

  function automatic logic port_ready(input int port);
    return (port == 0) ? s0_tready : s1_tready;
  endfunction

  task automatic check_value(input string name, input logic [255:0] expected,
                             input logic [255:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // packet pair plus the expected output, built from the header and lane rules
  task automatic build_pair(input int plen, input logic fin);
    axis_pkg::beat_t b0;
    axis_pkg::beat_t b1;
    axis_pkg::beat_t e;
    pkt0_q.delete();
    pkt1_q.delete();
    exp_q.delete();
    for (int i = 0; i < `AGG_HDR_BEATS; i++) begin
      b0 = random_beat();
      b1 = random_beat();
      b0.tkeep = '1;
      b1.tkeep = '1;
      if (i == `AGG_HDR_BEATS - 1) begin
        b0.tdata[`AGG_FIN_BIT] = fin;  // port 1 fin stays random
      end
      e = b0;
      if (i == 0) begin
        e.tdata[47:0] = `AGG_NEW_DEST_MAC;
      end
      pkt0_q.push_back(b0);
      pkt1_q.push_back(b1);
      exp_q.push_back(e);
    end
    for (int i = 0; i < plen; i++) begin
      b0 = random_beat();
      b1 = random_beat();
      b0.tlast = (i == plen - 1);
      b1.tlast = b0.tlast;
      e = b0;
      e.tdata[31:0] = b0.tdata[31:0] + b1.tdata[31:0];
      e.tdata[63:32] = b0.tdata[63:32] + b1.tdata[63:32];
      pkt0_q.push_back(b0);
      pkt1_q.push_back(b1);
      exp_q.push_back(e);
    end
  endtask

  // starts and ends 1 ns after a rising edge
  task automatic send_packet(input int port);
    int n;
    int waited;
    n = (port == 0) ? pkt0_q.size() : pkt1_q.size();
    for (int i = 0; i < n; i++) begin
      if (port == 0) begin
        s0_beat = pkt0_q[i];
        s0_tvalid = 1'b1;
      end else begin
        s1_beat = pkt1_q[i];
        s1_tvalid = 1'b1;
      end
      waited = 0;
      while (!port_ready(port) && waited < timeout_cycles) begin
        @(posedge axis_aclk);
        #1;
        waited++;
      end
      if (!port_ready(port)) begin
        errors++;
        $display("port %0d tready stayed low for %0d cycles", port, waited);
      end
      @(posedge axis_aclk);
      #1;
    end
    if (port == 0) begin
      s0_beat = '0;
      s0_tvalid = 1'b0;
    end else begin
      s1_beat = '0;
      s1_tvalid = 1'b0;
    end
  endtask

  task automatic wait_output(input string name, input int n);
    int waited;
    waited = 0;
    while (out_q.size() < n && waited < timeout_cycles) begin
      @(posedge axis_aclk);
      #1;
      waited++;
    end
    if (out_q.size() < n) begin
      errors++;
      $display("%s: output stopped after %0d of %0d beats", name, out_q.size(), n);
    end
    repeat (4) begin
      @(posedge axis_aclk);  // window for a stray extra beat
      #1;
    end
    busy = 1'b0;
  endtask

  task automatic drive_ready_random();
    for (int c = 0; busy && c < 4 * timeout_cycles; c++) begin
      @(posedge axis_aclk);
      #1;
      m_tready = (rand_bits(1) != 32'd0);
    end
    m_tready = 1'b1;
  endtask

  task automatic run_pair(input string name, input int plen, input logic fin,
                          input int p1_delay, input logic toggle,
                          input logic [31:0] exp_vidx);
    build_pair(plen, fin);
    out_q.delete();
    busy = 1'b1;
    fork
      send_packet(0);
      begin
        repeat (p1_delay) begin
          @(posedge axis_aclk);
          #1;
        end
        send_packet(1);
      end
      wait_output(name, exp_q.size());
      begin
        if (toggle) begin
          drive_ready_random();
        end
      end
    join
    m_tready = 1'b1;
    check_value($sformatf("%s length", name), exp_q.size(), out_q.size());
    for (int i = 0; i < exp_q.size() && i < out_q.size(); i++) begin
      check_value($sformatf("%s beat %0d", name, i), exp_q[i], out_q[i]);
    end
    check_value($sformatf("%s vector_index", name), exp_vidx, vector_index);
  endtask

  task automatic after_reset();
    @(posedge axis_aclk);
    #1;
    check_value("reset m_tvalid", 0, m_tvalid);
    check_value("reset vector_index", 0, vector_index);
    check_value("reset s0_tready", 1, s0_tready);
    check_value("reset s1_tready", 1, s1_tready);
  endtask

  task automatic index_sequence();
    run_pair("vector_index 0", 2, 1'b0, 0, 1'b0, 32'd1);
    run_pair("vector_index 1", 2, 1'b0, 0, 1'b0, 32'd2);
    run_pair("vector_index 2", 2, 1'b1, 0, 1'b0, 32'd0);  // fin restarts the run
  endtask

  task automatic header_rewrite();
    run_pair("header_rewrite", 1, 1'b0, 0, 1'b0, 32'd1);
  endtask

  task automatic lane_sums();
    run_pair("lane_sums", 6, 1'b1, 3, 1'b0, 32'd0);
  endtask

  // port 0 fills its FIFO while port 1 is still silent
  task automatic skew_backpressure();
    s0_was_full = 1'b0;
    run_pair("skew", 40, 1'b0, 60, 1'b1, 32'd1);
    if (!s0_was_full) begin
      errors++;
      $display("skew: s0_tready never fell while port 1 was idle");
    end
  endtask

  initial begin
    axis_resetn = 1'b0;
    s0_beat = '0;
    s0_tvalid = 1'b0;
    s1_beat = '0;
    s1_tvalid = 1'b0;
    m_tready = 1'b1;
    repeat (2) @(posedge axis_aclk);
    #1;
    axis_resetn = 1'b1;
    after_reset();
    index_sequence();
    header_rewrite();
    lane_sums();
    skew_backpressure();
    $display("agg_tb: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+logic
logic/axis_pkg.sv
logic/agg_pkg.sv
logic/beat_fifo.sv
logic/port_ingress.sv
logic/agg_combine.sv
logic/agg_top.sv
bench/agg_tb.sv

/* run.sh */
#!/bin/sh
# build and run the aggregation testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module agg_tb -f compile.f -o agg_sim
./obj_dir/agg_sim > sim.log 2>&1
cat sim.log
if grep -q "^No errors$" sim.log; then
  exit 0
fi
exit 1
